/* list.f */
hw/lc3b_types.sv
hw/regfile.sv
hw/decode.sv
hw/alu.sv
hw/execute.sv
hw/stage_latch.sv
hw/lc3b_core.sv
verification/tb_lc3b.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_lc3b -f list.f -o tb_lc3b
	@out="$$(./obj_dir/tb_lc3b)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* verification/tb_lc3b.sv */
module tb_lc3b;

    localparam logic [15:0] base_addr = 16'h3000;
    localparam int          mem_words = 64;
    localparam logic [3:0]  add_op    = 4'h1;
    localparam logic [3:0]  and_op    = 4'h5;
    localparam logic [3:0]  xor_op    = 4'h9;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        fetch_req;
    logic [15:0] fetch_addr;
    logic        fetch_ack = 1'b0;
    logic [15:0] instr = 16'h0000;
    logic        retire_valid;
    logic [15:0] retire_ir;
    logic [15:0] retire_value;
    logic [2:0]  retire_dr;
    logic [2:0]  retire_cc;

    logic [15:0] prog [mem_words];
    int          prog_len = 0;
    logic [31:0] lfsr_state = 32'hd372;
    string       test_name = "reset";
    int          err_count = 0;
    int          retired = 0;
    int          budget = 0;
    int          wait_left = 0;
    logic        req_seen = 1'b0;
    logic        req_prev = 1'b0;
    logic        ack_prev = 1'b0;
    logic [15:0] exp_ir [$];
    logic [2:0]  exp_dr [$];
    logic [15:0] exp_value [$];
    logic [2:0]  exp_cc [$];
    logic [15:0] exp_fetch [$];

    lc3b_core UUT (
        .clk,
        .rst_n,
        .fetch_req,
        .fetch_addr,
        .fetch_ack,
        .instr,
        .retire_valid,
        .retire_ir,
        .retire_value,
        .retire_dr,
        .retire_cc
    );

    always #20 clk = ~clk;

    // galois form, one step per bit.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int random_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic in_program(input logic [15:0] addr);
        logic [15:0] off;
        off = addr - base_addr;
        return !off[0] && int'(off[15:1]) < prog_len;
    endfunction

    function automatic logic [15:0] fetch_word(input logic [15:0] addr);
        logic [15:0] off;
        off = addr - base_addr;
        if (in_program(addr)) begin
            return prog[off[6:1]];
        end
        // ands with address-folded fields past the program end.
        return {4'h5, addr[11:0] ^ {8'h00, addr[15:12]}};
    endfunction

    function automatic logic [15:0] op_reg(input logic [3:0] op, input int dr,
                                           input int sr1, input int sr2);
        return {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
    endfunction

    function automatic logic [15:0] op_imm(input logic [3:0] op, input int dr,
                                           input int sr1, input int imm);
        return {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
    endfunction

    // kind 0 lshf, 1 rshfl, 3 rshfa.
    function automatic logic [15:0] shf(input int dr, input int sr, input int kind,
                                        input int amt);
        return {4'hd, dr[2:0], sr[2:0], kind[1:0], amt[3:0]};
    endfunction

    function automatic logic [15:0] lea(input int dr, input int off9);
        return {4'he, dr[2:0], off9[8:0]};
    endfunction

    function automatic logic [15:0] br(input int nzp, input int off9);
        return {4'h0, nzp[2:0], off9[8:0]};
    endfunction

    function automatic logic [2:0] cc_of(input logic [15:0] v);
        if (v[15]) begin
            return 3'b100;
        end
        if (v == 16'h0000) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    task automatic clear_program();
        prog_len = 0;
    endtask

    task automatic emit(input logic [15:0] w);
        prog[prog_len[5:0]] = w;
        prog_len++;
    endtask

    // walks the program in order and queues fetches and retires.
    task automatic build_reference();
        logic [15:0] regs [8];
        logic [2:0]  cc;
        logic [15:0] pc;
        logic [15:0] npc;
        logic [15:0] w;
        logic [15:0] b;
        logic [15:0] off;
        logic [15:0] res;
        int          steps;
        regs = '{default: 16'h0000};
        cc = 3'b010;
        pc = base_addr;
        steps = 0;
        while (in_program(pc) && steps < 4 * mem_words) begin
            w = fetch_word(pc);
            npc = pc + 16'd2;
            exp_fetch.push_back(pc);
            b = w[5] ? {{11{w[4]}}, w[4:0]} : regs[w[2:0]];
            off = {{6{w[8]}}, w[8:0], 1'b0};
            case (w[15:12])
                4'h1: res = regs[w[8:6]] + b;
                4'h5: res = regs[w[8:6]] & b;
                4'h9: res = regs[w[8:6]] ^ b;
                4'hd: begin
                    if (!w[4]) begin
                        res = regs[w[8:6]] << w[3:0];
                    end else if (!w[5]) begin
                        res = regs[w[8:6]] >> w[3:0];
                    end else begin
                        res = $signed(regs[w[8:6]]) >>> w[3:0];
                    end
                end
                // lea and br both form npc plus the byte offset.
                default: res = npc + off;
            endcase
            if (w[15:12] == 4'h0) begin
                if ((w[11:9] & cc) != 3'b000) begin
                    npc = res;
                end
            end else begin
                regs[w[11:9]] = res;
                if (w[15:12] != 4'he) begin
                    cc = cc_of(res);
                end
            end
            exp_ir.push_back(w);
            exp_dr.push_back(w[11:9]);
            exp_value.push_back(res);
            exp_cc.push_back(cc);
            pc = npc;
            steps++;
        end
    endtask

    task automatic run_program(input string name);
        budget += 200 * prog_len;
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
        test_name = name;
        exp_ir.delete();
        exp_dr.delete();
        exp_value.delete();
        exp_cc.delete();
        exp_fetch.delete();
        build_reference();
        repeat (9) @(posedge clk);
        rst_n <= 1'b1;
        while (exp_ir.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic check_value(input string field, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("Fail %s %s: expected %h, actual %h", test_name, field, expected, actual);
        end
    endtask

    // fetch responder with 0 to 3 cycles of wait before ack.
    always @(posedge clk) begin
        if (!rst_n) begin
            fetch_ack <= 1'b0;
            req_seen = 1'b0;
        end else if (fetch_ack) begin
            if (!fetch_req) begin
                fetch_ack <= 1'b0;
            end
        end else if (fetch_req) begin
            if (!req_seen) begin
                req_seen = 1'b1;
                wait_left = random_bits(2);
            end
            if (wait_left == 0) begin
                fetch_ack <= 1'b1;
                instr <= fetch_word(fetch_addr);
                req_seen = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (fetch_req && !req_prev) begin
                if (ack_prev) begin
                    err_count++;
                    $display("%s: fetch_req rose again while fetch_ack was still high",
                             test_name);
                end
                if (exp_fetch.size() != 0) begin
                    check_value("fetch_addr", exp_fetch.pop_front(), fetch_addr);
                end
            end
            if (retire_valid && exp_ir.size() != 0) begin
                check_value("retire_ir", exp_ir.pop_front(), retire_ir);
                check_value("retire_dr", 16'(exp_dr.pop_front()), 16'(retire_dr));
                check_value("retire_value", exp_value.pop_front(), retire_value);
                check_value("retire_cc", 16'(exp_cc.pop_front()), 16'(retire_cc));
                retired++;
            end
        end
        req_prev = fetch_req;
        ack_prev = fetch_ack;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: test %s made no progress within %0d cycles", test_name, cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic logic_ops_test();
        clear_program();
        emit(op_imm(add_op, 1, 0, 7));
        emit(op_imm(add_op, 2, 0, -3));
        emit(op_reg(add_op, 3, 1, 2));
        emit(op_reg(and_op, 4, 1, 2));
        emit(op_imm(and_op, 5, 2, -8));
        emit(op_reg(xor_op, 6, 1, 2));
        // not.
        emit(op_imm(xor_op, 7, 1, -1));
        emit(op_imm(add_op, 3, 2, 3));
        run_program("logic_ops");
    endtask

    task automatic shift_test();
        clear_program();
        emit(op_imm(add_op, 1, 0, -16));
        emit(op_imm(add_op, 2, 0, 13));
        emit(shf(3, 1, 0, 4));
        emit(shf(4, 1, 1, 2));
        emit(shf(5, 1, 3, 3));
        emit(shf(6, 2, 3, 1));
        emit(shf(7, 2, 0, 15));
        emit(shf(3, 2, 1, 4));
        run_program("shift");
    endtask

    task automatic lea_test();
        clear_program();
        emit(lea(1, 5));
        emit(lea(2, -4));
        emit(op_imm(add_op, 3, 0, -1));
        emit(lea(4, 0));
        emit(lea(5, 255));
        run_program("lea");
    endtask

    task automatic dependence_test();
        clear_program();
        emit(op_imm(add_op, 1, 0, 1));
        emit(op_reg(add_op, 1, 1, 1));
        emit(op_reg(add_op, 1, 1, 1));
        emit(op_imm(add_op, 2, 1, 3));
        emit(op_reg(and_op, 3, 2, 1));
        emit(op_reg(xor_op, 1, 3, 2));
        emit(shf(4, 1, 0, 3));
        emit(op_reg(add_op, 5, 4, 4));
        run_program("dependence");
    endtask

    // every mask against n, z and p; a taken br skips the lea marker.
    task automatic branch_test();
        clear_program();
        for (int c = 0; c < 3; c++) begin
            emit(op_imm(add_op, 1, 0, c - 1));
            for (int m = 0; m < 8; m++) begin
                emit(br(m, 1));
                emit(lea(7, m));
            end
        end
        emit(op_imm(add_op, 6, 0, 2));
        run_program("branch");
    endtask

    task automatic delay_test();
        clear_program();
        emit(op_imm(add_op, 1, 0, 5));
        emit(op_imm(add_op, 2, 0, -6));
        emit(op_reg(add_op, 3, 1, 2));
        emit(br(4, 2));
        emit(op_imm(add_op, 4, 0, 9));
        emit(op_imm(add_op, 5, 0, 9));
        emit(shf(4, 2, 3, 1));
        emit(lea(5, -2));
        emit(op_reg(xor_op, 6, 4, 5));
        emit(br(2, 1));
        emit(op_imm(and_op, 7, 6, 15));
        run_program("delay_a");
        run_program("delay_b");
    endtask

    initial begin
        logic_ops_test();
        shift_test();
        lea_test();
        dependence_test();
        branch_test();
        delay_test();
        $display("retired %0d instructions, errors %0d", retired, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* hw/lc3b_core.sv */
module lc3b_core (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 fetch_req,
    output lc3b_types::lc3b_word fetch_addr,
    input  logic                 fetch_ack,
    input  lc3b_types::lc3b_word instr,
    output logic                 retire_valid,
    output lc3b_types::lc3b_word retire_ir,
    output lc3b_types::lc3b_word retire_value,
    output lc3b_types::lc3b_reg  retire_dr,
    output lc3b_types::lc3b_nzp  retire_cc
);
    import lc3b_types::*;

    lc3b_word         pc;
    lc3b_nzp          cc;
    lc3b_nzp          new_cc;
    logic             capture;
    logic             fetch_start;
    logic             dec_valid;
    lc3b_word         dec_ir;
    lc3b_word         dec_npc;
    lc3b_control_word dec_cw;
    lc3b_reg          src_a;
    lc3b_reg          src_b;
    lc3b_reg          dec_dr;
    lc3b_word         reg_a;
    lc3b_word         reg_b;
    logic             dep_stall;
    logic             decode_br_stall;
    de_payload        de_d;
    de_payload        de_q;
    logic             de_valid;
    lc3b_word         ex_result;
    logic             br_taken;
    lc3b_word         br_target;
    logic             ex_load_cc;
    logic             ex_load_regfile;
    logic             ex_branch_stall;
    ew_payload        ew_d;
    ew_payload        ew_q;
    logic             ew_valid;
    logic             wb_load_regfile;
    logic             wb_load_cc;

    assign fetch_addr = pc;
    assign capture    = fetch_req && fetch_ack;
    // new request once ack is low and decode has room.
    assign fetch_start = !fetch_req && !fetch_ack && !decode_br_stall
                      && (!dec_valid || !dep_stall);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_req <= 1'b0;
            dec_valid <= 1'b0;
            pc        <= reset_pc;
            cc        <= 3'b010;
        end else begin
            if (capture) begin
                fetch_req <= 1'b0;
            end else if (fetch_start) begin
                fetch_req <= 1'b1;
            end
            if (capture) begin
                dec_valid <= 1'b1;
            end else if (!dep_stall) begin
                dec_valid <= 1'b0;
            end
            // branch resolves here; fall-through reloads npc.
            if (ex_branch_stall) begin
                pc <= br_taken ? br_target : de_q.npc;
            end else if (capture) begin
                pc <= pc + 16'd2;
            end
            if (wb_load_cc) begin
                cc <= new_cc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            dec_ir  <= instr;
            dec_npc <= pc + 16'd2;
        end
    end

    decode decode (
        .ir              (dec_ir),
        .valid_in        (dec_valid),
        .ex_valid        (de_valid),
        .ex_dr           (de_q.dr),
        .ex_load_regfile,
        .wb_valid        (ew_valid),
        .wb_dr           (ew_q.dr),
        .wb_load_regfile (ew_q.load_regfile),
        .cw              (dec_cw),
        .src_a,
        .src_b,
        .dr              (dec_dr),
        .dep_stall,
        .decode_br_stall
    );

    regfile regfile (
        .clk,
        .rst_n,
        .load  (wb_load_regfile),
        .dest  (ew_q.dr),
        .value (ew_q.result),
        .src_a,
        .src_b,
        .reg_a,
        .reg_b
    );

    assign de_d = '{npc: dec_npc, ir: dec_ir, cw: dec_cw,
                    sr1: reg_a, sr2: reg_b, dr: dec_dr};

    // a stalled decode sends a bubble on.
    stage_latch #(.payload_t(de_payload)) de_latch (
        .clk,
        .rst_n,
        .load     (1'b1),
        .flush    (dep_stall),
        .valid_in (dec_valid),
        .data_in  (de_d),
        .valid    (de_valid),
        .data     (de_q)
    );

    execute execute (
        .npc_in   (de_q.npc),
        .ir_in    (de_q.ir),
        .sr1      (de_q.sr1),
        .sr2      (de_q.sr2),
        .cw_in    (de_q.cw),
        .cc_in    (cc),
        .valid_in (de_valid),
        .result   (ex_result),
        .br_taken,
        .br_target,
        .ex_load_cc,
        .ex_load_regfile,
        .ex_branch_stall
    );

    assign ew_d = '{ir: de_q.ir, dr: de_q.dr, result: ex_result,
                    load_cc: ex_load_cc, load_regfile: ex_load_regfile};

    stage_latch #(.payload_t(ew_payload)) ew_latch (
        .clk,
        .rst_n,
        .load     (1'b1),
        .flush    (1'b0),
        .valid_in (de_valid),
        .data_in  (ew_d),
        .valid    (ew_valid),
        .data     (ew_q)
    );

    assign wb_load_regfile = ew_valid && ew_q.load_regfile;
    assign wb_load_cc      = ew_valid && ew_q.load_cc;
    assign new_cc = ew_q.result[15] ? 3'b100 : (ew_q.result == '0) ? 3'b010 : 3'b001;

    assign retire_valid = ew_valid;
    assign retire_ir    = ew_q.ir;
    assign retire_dr    = ew_q.dr;
    assign retire_value = ew_q.result;
    assign retire_cc    = wb_load_cc ? new_cc : cc;

    assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req && !fetch_ack |=> $stable(fetch_addr))
        else $error("fetch_addr changed during an open request");

    // no wrong-path instruction sits in decode while a branch resolves.
    assert property (@(posedge clk) disable iff (!rst_n)
        ex_branch_stall |-> !dec_valid)
        else $error("instruction fetched past an unresolved branch");

endmodule

/* hw/stage_latch.sv */
module stage_latch #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  logic     flush,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid,
    output payload_t data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data <= data_in;
        end
    end

endmodule

/* hw/execute.sv */
module execute (
    input  lc3b_types::lc3b_word         npc_in,
    input  lc3b_types::lc3b_word         ir_in,
    input  lc3b_types::lc3b_word         sr1,
    input  lc3b_types::lc3b_word         sr2,
    input  lc3b_types::lc3b_control_word cw_in,
    input  lc3b_types::lc3b_nzp          cc_in,
    input  logic                         valid_in,
    output lc3b_types::lc3b_word         result,
    output logic                         br_taken,
    output lc3b_types::lc3b_word         br_target,
    output logic                         ex_load_cc,
    output logic                         ex_load_regfile,
    output logic                         ex_branch_stall
);
    import lc3b_types::*;

    lc3b_word imm5;
    lc3b_word sr2mux_out;
    lc3b_word alu_out;
    lc3b_word addr1mux_out;
    lc3b_word addr2mux_out;
    lc3b_word offset;
    lc3b_word address;

    assign imm5       = {{11{ir_in[4]}}, ir_in[4:0]};
    assign sr2mux_out = cw_in.sr2mux_sel ? imm5 : sr2;

    alu alu (
        .aluop (cw_in.aluop),
        .a     (sr1),
        .b     (sr2mux_out),
        .f     (alu_out)
    );

    assign addr1mux_out = cw_in.addr1mux_sel ? sr1 : npc_in;

    always_comb begin
        case (cw_in.addr2mux_sel)
            addr2_zero:  addr2mux_out = '0;
            addr2_off6:  addr2mux_out = {{10{ir_in[5]}}, ir_in[5:0]};
            addr2_off9:  addr2mux_out = {{7{ir_in[8]}}, ir_in[8:0]};
            addr2_off11: addr2mux_out = {{5{ir_in[10]}}, ir_in[10:0]};
        endcase
    end

    // word offsets become byte offsets.
    assign offset    = cw_in.lshf_enable ? {addr2mux_out[14:0], 1'b0} : addr2mux_out;
    assign address   = addr1mux_out + offset;
    assign br_target = address;
    assign result    = cw_in.result_sel ? address : alu_out;

    assign ex_load_cc      = valid_in && cw_in.load_cc;
    assign ex_load_regfile = valid_in && cw_in.load_regfile;

    always_comb begin
        ex_branch_stall = valid_in && cw_in.branch_stall;
        // taken when any requested nzp bit is set in cc.
        br_taken = valid_in && (lc3b_opcode'(ir_in[15:12]) == op_br)
                && |(ir_in[11:9] & cc_in);
        assert (!br_taken || ex_branch_stall)
            else $error("taken branch was not marked as a branch by decode");
    end

endmodule

/* hw/alu.sv */
module alu (
    input  lc3b_types::lc3b_aluop aluop,
    input  lc3b_types::lc3b_word  a,
    input  lc3b_types::lc3b_word  b,
    output lc3b_types::lc3b_word  f
);
    import lc3b_types::*;

    logic [3:0] shamt;

    assign shamt = b[3:0];

    always_comb begin
        case (aluop)
            alu_add:    f = a + b;
            alu_and:    f = a & b;
            alu_xor:    f = a ^ b;
            alu_pass_b: f = b;
            alu_sll:    f = a << shamt;
            alu_srl:    f = a >> shamt;
            // fills with the sign bit.
            alu_sra:    f = lc3b_word'($signed(a) >>> shamt);
            default:    f = b;
        endcase
    end

endmodule

/* hw/decode.sv */
module decode (
    input  lc3b_types::lc3b_word         ir,
    input  logic                         valid_in,
    input  logic                         ex_valid,
    input  lc3b_types::lc3b_reg          ex_dr,
    input  logic                         ex_load_regfile,
    input  logic                         wb_valid,
    input  lc3b_types::lc3b_reg          wb_dr,
    input  logic                         wb_load_regfile,
    output lc3b_types::lc3b_control_word cw,
    output lc3b_types::lc3b_reg          src_a,
    output lc3b_types::lc3b_reg          src_b,
    output lc3b_types::lc3b_reg          dr,
    output logic                         dep_stall,
    output logic                         decode_br_stall
);
    import lc3b_types::*;

    lc3b_opcode opcode;
    logic       ex_pend;
    logic       wb_pend;
    logic       hit_a;
    logic       hit_b;
    logic       use_a;
    logic       use_b;
    logic       use_cc;

    assign opcode = lc3b_opcode'(ir[15:12]);
    assign src_a  = ir[8:6];
    assign src_b  = ir[2:0];
    assign dr     = ir[11:9];

    assign ex_pend = ex_valid && ex_load_regfile;
    assign wb_pend = wb_valid && wb_load_regfile;
    assign hit_a   = (ex_pend && ex_dr == src_a) || (wb_pend && wb_dr == src_a);
    assign hit_b   = (ex_pend && ex_dr == src_b) || (wb_pend && wb_dr == src_b);

    always_comb begin
        cw     = '0;
        use_a  = 1'b0;
        use_b  = 1'b0;
        use_cc = 1'b0;
        if (valid_in) begin
            case (opcode)
                op_add, op_and, op_xor: begin
                    cw.aluop = (opcode == op_add) ? alu_add :
                               (opcode == op_and) ? alu_and : alu_xor;
                    cw.sr2mux_sel   = ir[5];
                    cw.load_cc      = 1'b1;
                    cw.load_regfile = 1'b1;
                    use_a           = 1'b1;
                    use_b           = !ir[5];
                end
                op_shf: begin
                    // ir[4] picks right, ir[5] arithmetic.
                    cw.aluop        = !ir[4] ? alu_sll : (ir[5] ? alu_sra : alu_srl);
                    cw.sr2mux_sel   = 1'b1;
                    cw.load_cc      = 1'b1;
                    cw.load_regfile = 1'b1;
                    use_a           = 1'b1;
                end
                op_lea: begin
                    cw.aluop        = alu_pass_b;
                    cw.addr2mux_sel = addr2_off9;
                    cw.lshf_enable  = 1'b1;
                    cw.result_sel   = 1'b1;
                    cw.load_regfile = 1'b1;
                end
                op_br: begin
                    cw.addr2mux_sel = addr2_off9;
                    cw.lshf_enable  = 1'b1;
                    cw.result_sel   = 1'b1;
                    cw.branch_stall = 1'b1;
                    use_cc          = 1'b1;
                end
                default: ;
            endcase
        end
        // br reads cc; every cc writer also writes a register.
        dep_stall = (use_a && hit_a) || (use_b && hit_b)
                 || (use_cc && (ex_pend || wb_pend));
        decode_br_stall = cw.branch_stall;
    end

endmodule

/* hw/regfile.sv */
module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word value,
    input  lc3b_types::lc3b_reg  src_a,
    input  lc3b_types::lc3b_reg  src_b,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);
    import lc3b_types::*;

    lc3b_word regs [reg_count];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= value;
        end
    end

    // reads return the value from before a same-cycle write.
    assign reg_a = regs[src_a];
    assign reg_b = regs[src_b];

endmodule

/* hw/lc3b_types.sv */
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    // n, z, p from msb down.
    typedef logic [2:0]  lc3b_nzp;

    localparam lc3b_word reset_pc  = 16'h3000;
    localparam int       reg_count = 8;

    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_xor = 4'b1001,
        op_shf = 4'b1101,
        op_lea = 4'b1110
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_xor,
        alu_pass_b,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    typedef enum logic [1:0] {
        addr2_zero,
        addr2_off6,
        addr2_off9,
        addr2_off11
    } lc3b_addr2sel;

    typedef struct packed {
        lc3b_aluop    aluop;
        // imm5 when set.
        logic         sr2mux_sel;
        // sr1 when set, npc otherwise.
        logic         addr1mux_sel;
        lc3b_addr2sel addr2mux_sel;
        logic         lshf_enable;
        // address adder when set, so lea writes the address.
        logic         result_sel;
        logic         load_cc;
        logic         load_regfile;
        // marks a br.
        logic         branch_stall;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_word         npc;
        lc3b_word         ir;
        lc3b_control_word cw;
        lc3b_word         sr1;
        lc3b_word         sr2;
        lc3b_reg          dr;
    } de_payload;

    typedef struct packed {
        lc3b_word ir;
        lc3b_reg  dr;
        lc3b_word result;
        logic     load_cc;
        logic     load_regfile;
    } ew_payload;

endpackage
